// ==== design/cmos_dac_framer.sv ====
// DAC sample framer

`timescale 1ns/100ps
`default_nettype none

module cmos_dac_framer import cmos_dac_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire                         tx_clk,
  input  wire                         rst_n,

  // upper half carries the p bits, lower half the n bits
  input  wire       [2*NUM_LANES-1:0] dac_data,

  output lane_ddr_t [NUM_LANES-1:0]   lane_ddr,
  output lane_ddr_t                   frame_ddr
);

  // internal signals
  logic frame_phase;

  // **********************************************************************
  // data lanes
  // **********************************************************************

  // lane k takes bit k of each half, p from the top and n from the bottom
  always_ff @(posedge tx_clk) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_ddr[k].p <= dac_data[NUM_LANES + k];
      lane_ddr[k].n <= dac_data[k];
    end
  end

  // **********************************************************************
  // frame lane
  // **********************************************************************

  // the phase flop marks even cycles counted from reset release,
  // frame is high for the first half of every even cycle
  always_ff @(posedge tx_clk) begin
    if (!rst_n) begin
      frame_phase <= 1'b0;
      frame_ddr   <= '0;
    end else begin
      frame_phase   <= ~frame_phase;
      frame_ddr.p   <= ~frame_phase;
      frame_ddr.n   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/cmos_dac_if.sv ====
// CMOS DAC output interface

`timescale 1ns/100ps
`default_nettype none

module cmos_dac_if import cmos_dac_pkg::*; #(
  parameter int NUM_LANES      = DEF_NUM_LANES,
  parameter int IODELAY_ENABLE = 1
) (
  input  wire                   rst_n,

  // sample interface
  input  wire                   tx_clk,
  input  wire [2*NUM_LANES-1:0] dac_data,

  // pad outputs
  output wire [NUM_LANES-1:0]   tx_data_out,
  output wire                   tx_frame_out,

  // processor bus
  input  wire                   up_clk,
  input  wire                   up_wreq,
  input  up_wr_t                up_wr,
  output wire                   up_wack,
  input  wire                   up_rreq,
  input  up_addr_t              up_raddr,
  output up_data_t              up_rdata,
  output wire                   up_rack,

  // delay reference clock and lock status
  input  wire                   delay_clk,
  output wire                   delay_locked
);

  // internal signals
  lane_ddr_t [NUM_LANES-1:0] lane_ddr_s;
  lane_ddr_t                 frame_ddr_s;
  logic      [NUM_LANES-1:0] tap_ld_s;
  tap_t                      tap_wdata_s;
  tap_t      [NUM_LANES-1:0] tap_rdata_s;

  // **********************************************************************
  // framer, tx_clk domain
  // **********************************************************************

  cmos_dac_framer #(
    .NUM_LANES (NUM_LANES)
  ) i_framer (
    .tx_clk    (tx_clk),
    .rst_n     (rst_n),
    .dac_data  (dac_data),
    .lane_ddr  (lane_ddr_s),
    .frame_ddr (frame_ddr_s)
  );

  // **********************************************************************
  // output lanes, DDR register then delay then pad
  // **********************************************************************

  generate
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
      cmos_out_lane #(
        .IODELAY_ENABLE (IODELAY_ENABLE)
      ) i_lane (
        .tx_clk    (tx_clk),
        .ddr_in    (lane_ddr_s[k]),
        .data_out  (tx_data_out[k]),
        .up_clk    (up_clk),
        .tap_ld    (tap_ld_s[k]),
        .tap_wdata (tap_wdata_s),
        .tap_rdata (tap_rdata_s[k]),
        .delay_clk (delay_clk),
        .rst_n     (rst_n)
      );
    end
  endgenerate

  // frame lane keeps the same latency as the data lanes,
  // its tap never loads and stays at zero
  cmos_out_lane #(
    .IODELAY_ENABLE (IODELAY_ENABLE)
  ) i_frame_lane (
    .tx_clk    (tx_clk),
    .ddr_in    (frame_ddr_s),
    .data_out  (tx_frame_out),
    .up_clk    (up_clk),
    .tap_ld    (1'b0),
    .tap_wdata ('0),
    .tap_rdata (),
    .delay_clk (delay_clk),
    .rst_n     (rst_n)
  );

  // **********************************************************************
  // delay controller and register bank
  // **********************************************************************

  cmos_delay_ctrl #(
    .IODELAY_ENABLE (IODELAY_ENABLE)
  ) i_delay_ctrl (
    .delay_clk    (delay_clk),
    .rst_n        (rst_n),
    .delay_locked (delay_locked)
  );

  cmos_delay_regs #(
    .NUM_LANES (NUM_LANES)
  ) i_delay_regs (
    .up_clk       (up_clk),
    .rst_n        (rst_n),
    .up_wreq      (up_wreq),
    .up_wr        (up_wr),
    .up_wack      (up_wack),
    .up_rreq      (up_rreq),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .up_rack      (up_rack),
    .delay_locked (delay_locked),
    .tap_ld       (tap_ld_s),
    .tap_wdata    (tap_wdata_s),
    .tap_rdata    (tap_rdata_s)
  );

endmodule

`default_nettype wire

// ==== design/cmos_dac_pkg.sv ====
// CMOS DAC interface shared definitions

`default_nettype none

package cmos_dac_pkg;

  // **********************************************************************
  // delay and lane types
  // **********************************************************************

  // tap count of the output delay, one delay_clk period per step
  typedef logic [4:0] tap_t;

  // bit pair sent by one lane in one tx_clk cycle
  // p goes out while tx_clk is high, n while it is low
  typedef struct packed {
    logic p;
    logic n;
  } lane_ddr_t;

  // **********************************************************************
  // processor bus types
  // **********************************************************************

  typedef logic [7:0]  up_addr_t;
  typedef logic [31:0] up_data_t;

  // address and data travel together with the write strobe
  typedef struct packed {
    up_addr_t addr;
    up_data_t data;
  } up_wr_t;

  // **********************************************************************
  // register map and default sizes
  // **********************************************************************

  // status register holds lock in bit 0 and the lane count in bits 15:8
  localparam up_addr_t ADDR_STATUS = 8'h01;

  // lane k has its tap register at this base plus k
  localparam up_addr_t ADDR_TAP_BASE = 8'h10;

  // delay_clk cycles from reset release until the delay controller locks
  localparam int LOCK_CYCLES = 32;

  // default data lane count, the frame lane comes on top of it
  localparam int DEF_NUM_LANES = 8;

endpackage

`default_nettype wire

// ==== design/cmos_delay_ctrl.sv ====
// Delay controller model

`timescale 1ns/100ps
`default_nettype none

module cmos_delay_ctrl import cmos_dac_pkg::*; #(
  parameter int IODELAY_ENABLE = 1
) (
  input  wire  delay_clk,
  input  wire  rst_n,
  output logic delay_locked
);

  // wide enough to hold LOCK_CYCLES itself
  localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

  generate
    if (IODELAY_ENABLE == 1) begin : g_ctrl
      logic [CNT_W-1:0] settle_cnt;

      // the counter runs from reset release and stops once locked,
      // lock comes on the LOCK_CYCLES-th delay_clk edge after release
      always_ff @(posedge delay_clk) begin
        if (!rst_n) begin
          settle_cnt   <= '0;
          delay_locked <= 1'b0;
        end else if (!delay_locked) begin
          settle_cnt <= settle_cnt + 1'b1;
          if (settle_cnt == CNT_W'(LOCK_CYCLES - 1)) begin
            delay_locked <= 1'b1;
          end
        end
      end
    end else begin : g_no_ctrl
      // without delay elements there is nothing to calibrate
      always_ff @(posedge delay_clk) begin
        if (!rst_n) begin
          delay_locked <= 1'b0;
        end else begin
          delay_locked <= 1'b1;
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

// ==== design/cmos_delay_regs.sv ====
// Delay tap register bank

`timescale 1ns/100ps
`default_nettype none

module cmos_delay_regs import cmos_dac_pkg::*; #(
  parameter int NUM_LANES = DEF_NUM_LANES
) (
  input  wire                       up_clk,
  input  wire                       rst_n,

  // write strobe and its acknowledge
  input  wire                       up_wreq,
  input  up_wr_t                    up_wr,
  output logic                      up_wack,

  // read strobe, data comes back with the acknowledge
  input  wire                       up_rreq,
  input  up_addr_t                  up_raddr,
  output up_data_t                  up_rdata,
  output logic                      up_rack,

  // delay controller status, still in the delay_clk domain
  input  wire                       delay_locked,

  // lane tap interface
  output logic     [NUM_LANES-1:0]  tap_ld,
  output tap_t                      tap_wdata,
  input  tap_t     [NUM_LANES-1:0]  tap_rdata
);

  // internal signals
  logic     locked_m1;
  logic     locked_m2;
  up_data_t rdata_s;

  // **********************************************************************
  // lock status synchronizer
  // **********************************************************************

  always_ff @(posedge up_clk) begin
    if (!rst_n) begin
      locked_m1 <= 1'b0;
      locked_m2 <= 1'b0;
    end else begin
      locked_m1 <= delay_locked;
      locked_m2 <= locked_m1;
    end
  end

  // **********************************************************************
  // write path
  // **********************************************************************

  // each tap write turns into a load pulse on exactly one lane,
  // it lands in the same cycle as the acknowledge
  always_ff @(posedge up_clk) begin
    if (!rst_n) begin
      up_wack <= 1'b0;
      tap_ld  <= '0;
    end else begin
      up_wack <= up_wreq;
      tap_ld  <= '0;
      if (up_wreq) begin
        for (int k = 0; k < NUM_LANES; k++) begin
          if (up_wr.addr == ADDR_TAP_BASE + up_addr_t'(k)) begin
            tap_ld[k] <= 1'b1;
          end
        end
      end
    end
  end

  // tap value is shared by all lanes, only the pulsed lane takes it
  always_ff @(posedge up_clk) begin
    if (up_wreq) begin
      tap_wdata <= tap_t'(up_wr.data);
    end
  end

  // **********************************************************************
  // read path
  // **********************************************************************

  // unmapped addresses fall through to zero
  always_comb begin
    rdata_s = '0;
    if (up_raddr == ADDR_STATUS) begin
      rdata_s[0]    = locked_m2;
      rdata_s[15:8] = 8'(NUM_LANES);
    end
    for (int k = 0; k < NUM_LANES; k++) begin
      if (up_raddr == ADDR_TAP_BASE + up_addr_t'(k)) begin
        rdata_s = up_data_t'(tap_rdata[k]);
      end
    end
  end

  // read data is held at zero outside the acknowledge cycle
  always_ff @(posedge up_clk) begin
    if (!rst_n) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rdata_s : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/cmos_out_lane.sv ====
// CMOS output lane

`timescale 1ns/100ps
`default_nettype none

module cmos_out_lane import cmos_dac_pkg::*; #(
  parameter int IODELAY_ENABLE = 1
) (
  // data interface
  input  wire       tx_clk,
  input  lane_ddr_t ddr_in,
  output wire       data_out,

  // tap interface, processor clock domain
  input  wire       up_clk,
  input  wire       tap_ld,
  input  tap_t      tap_wdata,
  output tap_t      tap_rdata,

  // delay reference clock and reset
  input  wire       delay_clk,
  input  wire       rst_n
);

  // one delay_clk period per tap, the deepest tap uses every stage
  localparam int DLY_DEPTH = 2 ** $bits(tap_t);

  // internal signals
  lane_ddr_t ddr_q;
  logic      oddr_s;

  // **********************************************************************
  // same-edge DDR output register
  // **********************************************************************

  // both halves are captured together on the rising edge
  always_ff @(posedge tx_clk) begin
    ddr_q <= ddr_in;
  end

  // p is sent in the high phase and n in the low phase of the same cycle,
  // so the pair leaves one full cycle after the framer presented it
  assign oddr_s = tx_clk ? ddr_q.p : ddr_q.n;

  // **********************************************************************
  // variable-load output delay
  // **********************************************************************

  generate
    if (IODELAY_ENABLE == 1) begin : g_delay
      tap_t                 tap_q;
      logic [DLY_DEPTH-1:0] dly_sr;

      // tap value loads on the processor clock and starts at zero
      always_ff @(posedge up_clk) begin
        if (!rst_n) begin
          tap_q <= '0;
        end else if (tap_ld) begin
          tap_q <= tap_wdata;
        end
      end

      // the delay line samples the DDR output once per delay_clk period,
      // stage 0 already holds one period of delay
      always_ff @(posedge delay_clk) begin
        dly_sr <= {dly_sr[DLY_DEPTH-2:0], oddr_s};
      end

      // output taken at the loaded tap, total delay is tap plus one period
      assign data_out  = dly_sr[tap_q];
      assign tap_rdata = tap_q;
    end else begin : g_bypass
      // no delay element, the DDR value goes straight to the pad
      assign data_out  = oddr_s;
      assign tap_rdata = '0;
    end
  endgenerate

endmodule

`default_nettype wire

// ==== dv/cmos_dac_if_checker.sv ====
// Bound bus, lock and frame assertions

`timescale 1ns/100ps
`default_nettype none

module cmos_dac_if_checker import cmos_dac_pkg::*; (
  input wire up_clk,
  input wire delay_clk,
  input wire tx_clk,
  input wire rst_n,
  input wire up_wreq,
  input wire up_wack,
  input wire up_rreq,
  input wire up_rack,
  input wire delay_locked,
  input wire tx_frame_out
);

  // delay_clk periods in one tx_clk period of the testbench clocks
  localparam int DLY_PER_TX = 8;

  // number of assertion failures so far
  int fail_cnt = 0;

  // delay_clk edges since reset release
  // the count stops once it has passed the lock point
  int unsigned rel_cnt;

  always_ff @(posedge delay_clk) begin
    if (!rst_n) begin
      rel_cnt <= 0;
    end else if (rel_cnt <= LOCK_CYCLES) begin
      rel_cnt <= rel_cnt + 1;
    end
  end

  // **********************************************************************
  // bus acknowledges
  // **********************************************************************

  // reset clears both acknowledges by the next up_clk edge
  a_ack_reset: assert property (@(posedge up_clk) !rst_n |=> !up_wack && !up_rack)
    else begin
      fail_cnt++;
      $error("acknowledge active after a reset cycle");
    end

  // every request gets its acknowledge exactly one cycle later
  a_wack_after_req: assert property (@(posedge up_clk) disable iff (!rst_n)
    up_wreq |=> up_wack)
    else begin
      fail_cnt++;
      $error("write request not acknowledged one cycle later");
    end

  a_rack_after_req: assert property (@(posedge up_clk) disable iff (!rst_n)
    up_rreq |=> up_rack)
    else begin
      fail_cnt++;
      $error("read request not acknowledged one cycle later");
    end

  // no acknowledge without a request, and each one lasts a single cycle
  a_wack_single: assert property (@(posedge up_clk) disable iff (!rst_n)
    up_wack |-> $past(up_wreq) ##1 !up_wack)
    else begin
      fail_cnt++;
      $error("write acknowledge without request or longer than one cycle");
    end

  a_rack_single: assert property (@(posedge up_clk) disable iff (!rst_n)
    up_rack |-> $past(up_rreq) ##1 !up_rack)
    else begin
      fail_cnt++;
      $error("read acknowledge without request or longer than one cycle");
    end

  // **********************************************************************
  // delay controller lock and frame lane output
  // **********************************************************************

  a_lock_reset: assert property (@(posedge delay_clk) !rst_n |=> !delay_locked)
    else begin
      fail_cnt++;
      $error("delay_locked high after a reset cycle");
    end

  // lock must appear on the LOCK_CYCLES-th delay_clk edge after release
  a_lock_time: assert property (@(posedge delay_clk) disable iff (!rst_n)
    delay_locked == (rel_cnt >= LOCK_CYCLES))
    else begin
      fail_cnt++;
      $error("delay_locked rose at the wrong delay_clk cycle");
    end

  // the frame lane alternates its p bit every tx_clk cycle and keeps n low,
  // so a sample taken in the high phase differs from the one a tx_clk period
  // earlier and a sample taken in the low phase does not
  a_frame_pattern: assert property (@(posedge delay_clk) disable iff (!rst_n)
    delay_locked |->
      ((tx_frame_out != $past(tx_frame_out, DLY_PER_TX)) == $past(tx_clk)))
    else begin
      fail_cnt++;
      $error("tx_frame_out does not follow the frame pattern after lock");
    end

endmodule

bind cmos_dac_if cmos_dac_if_checker i_checker (
  .up_clk       (up_clk),
  .delay_clk    (delay_clk),
  .tx_clk       (tx_clk),
  .rst_n        (rst_n),
  .up_wreq      (up_wreq),
  .up_wack      (up_wack),
  .up_rreq      (up_rreq),
  .up_rack      (up_rack),
  .delay_locked (delay_locked),
  .tx_frame_out (tx_frame_out)
);

`default_nettype wire

// ==== dv/cmos_dac_if_tb.sv ====
// CMOS DAC interface testbench

`timescale 1ns/100ps
`default_nettype none

module cmos_dac_if_tb import cmos_dac_pkg::*; ();

  localparam int NUM_LANES    = 8;
  localparam int BUS_TIMEOUT  = 16;
  localparam int LOCK_TIMEOUT = 4 * LOCK_CYCLES;

  // clocks start low, tx_clk and up_clk share their phase
  logic tx_clk    = 1'b0;
  logic up_clk    = 1'b0;
  logic delay_clk = 1'b0;

  // DUT inputs
  logic                   rst_n;
  logic [2*NUM_LANES-1:0] dac_data;
  logic                   up_wreq;
  up_wr_t                 up_wr;
  logic                   up_rreq;
  up_addr_t               up_raddr;

  // DUT outputs
  wire  [NUM_LANES-1:0]   tx_data_out;
  wire                    tx_frame_out;
  wire                    up_wack;
  wire                    up_rack;
  wire  [31:0]            up_rdata;
  wire                    delay_locked;

  // stimulus state
  int                     seed = 32'h503f_53c7;
  logic [31:0]            rnd_word;
  tap_t [NUM_LANES-1:0]   tap_plan;
  up_data_t               junk_data;

  // reference model, index NUM_LANES is the frame lane
  lane_ddr_t [NUM_LANES:0]       frm_q  = '0;
  lane_ddr_t [NUM_LANES:0]       oreg_q = '0;
  logic [NUM_LANES:0][31:0]      hist   = '0;
  tap_t [NUM_LANES-1:0]          exp_tap;
  logic [15:0]                   frame_cyc = '0;
  logic                          chk_en;

  always #20 tx_clk = ~tx_clk;
  always #20 up_clk = ~up_clk;
  always #2.5 delay_clk = ~delay_clk;

  cmos_dac_if #(
    .NUM_LANES      (NUM_LANES),
    .IODELAY_ENABLE (1)
  ) i_dut (
    .rst_n        (rst_n),
    .tx_clk       (tx_clk),
    .dac_data     (dac_data),
    .tx_data_out  (tx_data_out),
    .tx_frame_out (tx_frame_out),
    .up_clk       (up_clk),
    .up_wreq      (up_wreq),
    .up_wr        (up_wr),
    .up_wack      (up_wack),
    .up_rreq      (up_rreq),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .up_rack      (up_rack),
    .delay_clk    (delay_clk),
    .delay_locked (delay_locked)
  );

  // **********************************************************************
  // failure handling and bus tasks
  // **********************************************************************

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // a tap write reaches the delay line at the edge where the tb sees the ack
  task automatic bus_write(input up_addr_t addr, input up_data_t data);
    int wait_cnt;
    wait_cnt = 0;
    up_wr   <= '{addr: addr, data: data};
    up_wreq <= 1'b1;
    @(posedge up_clk);
    up_wreq <= 1'b0;
    while (!up_wack) begin
      @(posedge up_clk);
      wait_cnt++;
      if (wait_cnt > BUS_TIMEOUT) begin
        fail_run("no write acknowledge from the DUT");
      end
    end
    if (addr >= ADDR_TAP_BASE && addr < ADDR_TAP_BASE + up_addr_t'(NUM_LANES)) begin
      exp_tap[addr - ADDR_TAP_BASE] <= tap_t'(data);
    end
  endtask

  task automatic bus_read(input up_addr_t addr, output up_data_t data);
    int wait_cnt;
    wait_cnt = 0;
    up_raddr <= addr;
    up_rreq  <= 1'b1;
    @(posedge up_clk);
    up_rreq <= 1'b0;
    while (!up_rack) begin
      @(posedge up_clk);
      wait_cnt++;
      if (wait_cnt > BUS_TIMEOUT) begin
        fail_run("no read acknowledge from the DUT");
      end
    end
    data = up_rdata;
  endtask

  // every lane against its own tap, the frame lane always at tap 0
  task automatic check_lanes();
    for (int k = 0; k < NUM_LANES; k++) begin
      check_value($sformatf("tx_data_out[%0d]", k), 32'(tx_data_out[k]),
                  32'(hist[k][exp_tap[k]]));
    end
    check_value("tx_frame_out", 32'(tx_frame_out), 32'(hist[NUM_LANES][0]));
  endtask

  // **********************************************************************
  // stimulus and reference model
  // **********************************************************************

  always @(posedge tx_clk) begin
    rnd_word = $random(seed);
    dac_data <= rnd_word[2*NUM_LANES-1:0];
  end

  // sample word registered at one edge, sent as a DDR pair after the next,
  // frame pair is {1,0} on even cycles counted from reset release
  always @(posedge tx_clk) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      frm_q[k].p <= dac_data[NUM_LANES + k];
      frm_q[k].n <= dac_data[k];
    end
    if (!rst_n) begin
      frm_q[NUM_LANES] <= '0;
      frame_cyc        <= '0;
    end else begin
      frm_q[NUM_LANES].p <= ~frame_cyc[0];
      frm_q[NUM_LANES].n <= 1'b0;
      frame_cyc          <= frame_cyc + 1'b1;
    end
    oreg_q <= frm_q;
  end

  // expected pad stream at delay_clk resolution, bit 0 is one period old
  always @(posedge delay_clk) begin
    for (int k = 0; k <= NUM_LANES; k++) begin
      hist[k] <= {hist[k][30:0], (tx_clk ? oreg_q[k].p : oreg_q[k].n)};
    end
  end

  // outputs compared 1 ns after each delay_clk edge, away from every clock edge
  always begin
    @(posedge delay_clk);
    #1;
    if (chk_en) begin
      check_lanes();
    end
  end

  always @(posedge up_clk) begin
    if (i_dut.i_checker.fail_cnt != 0) begin
      fail_run("an assertion in the bound checker failed");
    end
  end

  initial begin : main_flow
    up_data_t rd;
    int       wait_cnt;

    rst_n    = 1'b0;
    dac_data = '0;
    up_wreq  = 1'b0;
    up_wr    = '0;
    up_rreq  = 1'b0;
    up_raddr = '0;
    chk_en   = 1'b0;
    exp_tap  = '0;

    // taps and the unmapped write word are drawn before the clocks run
    for (int k = 0; k < NUM_LANES; k++) begin
      tap_plan[k] = tap_t'($random(seed));
    end
    junk_data = $random(seed);

    repeat (16) @(posedge tx_clk);
    rst_n <= 1'b1;

    // nothing locked or acknowledged right after release
    @(posedge up_clk);
    check_value("delay_locked", 32'(delay_locked), 32'h0);
    check_value("up_wack", 32'(up_wack), 32'h0);
    check_value("up_rack", 32'(up_rack), 32'h0);

    wait_cnt = 0;
    while (!delay_locked) begin
      @(posedge delay_clk);
      wait_cnt++;
      if (wait_cnt > LOCK_TIMEOUT) begin
        fail_run("delay_locked never rose after reset");
      end
    end

    // two flops of sync before the status register sees lock
    repeat (3) @(posedge up_clk);
    chk_en = 1'b1;
    bus_read(ADDR_STATUS, rd);
    check_value("up_rdata status", rd, {16'h0, 8'(NUM_LANES), 7'h0, 1'b1});

    // streaming with every tap at zero
    repeat (24) @(posedge tx_clk);

    // random taps, each read back and then streamed for a while
    for (int k = 0; k < NUM_LANES; k++) begin
      bus_write(ADDR_TAP_BASE + up_addr_t'(k), up_data_t'(tap_plan[k]));
      bus_read(ADDR_TAP_BASE + up_addr_t'(k), rd);
      check_value($sformatf("up_rdata tap %0d", k), rd, up_data_t'(tap_plan[k]));
      repeat (8) @(posedge up_clk);
    end

    // unmapped addresses, including the slot just past the last lane
    bus_write(8'h40, junk_data);
    bus_read(8'h40, rd);
    check_value("up_rdata addr 0x40", rd, 32'h0);
    bus_read(ADDR_TAP_BASE + up_addr_t'(NUM_LANES), rd);
    check_value("up_rdata addr past lanes", rd, 32'h0);

    // deepest tap on lane 0, lane 1 back to zero
    bus_write(ADDR_TAP_BASE, 32'd31);
    bus_read(ADDR_TAP_BASE, rd);
    check_value("up_rdata tap 0", rd, 32'd31);
    bus_write(ADDR_TAP_BASE + 8'd1, 32'd0);
    repeat (40) @(posedge tx_clk);

    if (i_dut.i_checker.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("the bound checker counted failed assertions");
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module cmos_dac_if_tb -f verilog.f || exit 1
out=$(./obj_dir/Vcmos_dac_if_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1

// ==== verilog.f ====
design/cmos_dac_pkg.sv
design/cmos_dac_framer.sv
design/cmos_out_lane.sv
design/cmos_delay_ctrl.sv
design/cmos_delay_regs.sv
design/cmos_dac_if.sv
dv/cmos_dac_if_checker.sv
dv/cmos_dac_if_tb.sv
